//--- hw/uartPkg.sv
// Shared UART constants and register-word layout, referenced by scoped name from every block
`default_nettype none

package uartPkg;

    // -------------------------------------------------------------------------
    // Widths and serial framing
    // -------------------------------------------------------------------------
    parameter int busWidth     = 32;
    parameter int byteWidth    = 8;
    parameter int divWidth     = 16;
    parameter int overSample   = 16;             // Ticks per bit
    parameter int resetDivisor = 1;

    // Word offsets, HADDR[3:2]
    parameter logic [1:0] dataOffset   = 2'd0;   // Write sends, read pops
    parameter logic [1:0] statusOffset = 2'd1;   // Read only
    parameter logic [1:0] ctrlOffset   = 2'd2;

    // Status word bits
    parameter int statRxReady  = 0;
    parameter int statTxBusy   = 1;
    parameter int statOverrun  = 2;
    parameter int statFrameErr = 3;
    parameter int dataValidBit = 8;              // FIFO had a byte

    // One bus word, seen as transmit data or as control
    typedef union packed {
        struct packed {
            logic [23:0] unused;
            logic [7:0]  txData;
        } txView;
        struct packed {
            logic [14:0] reserved;
            logic        rxIrqEn;                // Bit 16
            logic [15:0] divisor;
        } ctrlView;
    } regWord;

endpackage

`default_nettype wire

//--- hw/uartBaudTick.sv
// Baud tick source, one clock wide pulse at 16x the bit rate for both serial blocks
`timescale 1ns/1ps
`default_nettype none

module uartBaudTick (
    input  logic                          clk,
    input  logic                          RSTn,
    input  logic [uartPkg::divWidth-1:0]  divisor,  // Clocks per tick minus one
    output logic                          tick
);

    logic [uartPkg::divWidth-1:0] count;

    // Down counter, reload on zero
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count == '0)
        begin
            count <= divisor;                       // New divisor picked up here
            tick  <= 1'b1;
        end
        else
        begin
            count <= count - 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/uartReceiver.sv
// 8N1 serial receiver with 16x oversampling, pushes each good byte into the receive FIFO
`timescale 1ns/1ps
`default_nettype none

module uartReceiver (
    input  logic                           clk,
    input  logic                           RSTn,
    input  logic                           tick,
    input  logic                           RXD,
    output logic [uartPkg::byteWidth-1:0]  rxByte,
    output logic                           rxValid,   // One cycle, byte good
    output logic                           frameErr   // One cycle, stop bit low
);

    localparam int cntWidth = $clog2(uartPkg::overSample);
    localparam int bitWidth = $clog2(uartPkg::byteWidth);

    localparam logic [cntWidth-1:0] halfBit  = cntWidth'(uartPkg::overSample / 2 - 1);
    localparam logic [cntWidth-1:0] lastTick = cntWidth'(uartPkg::overSample - 1);
    localparam logic [bitWidth-1:0] lastBit  = bitWidth'(uartPkg::byteWidth - 1);

    localparam logic [1:0] idleSt  = 2'd0;
    localparam logic [1:0] startSt = 2'd1;
    localparam logic [1:0] dataSt  = 2'd2;
    localparam logic [1:0] stopSt  = 2'd3;

    logic                          rxMeta;
    logic                          rxSync;
    logic                          rxPrev;    // For edge detect
    logic [1:0]                    state;
    logic [cntWidth-1:0]           tickCnt;
    logic [bitWidth-1:0]           bitCnt;
    logic [uartPkg::byteWidth-1:0] shiftReg;
    logic                          sampleNow;

    // -------------------------------------------------------------------------
    // Input synchronizer, idle line is high
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end
        else
        begin
            rxMeta <= RXD;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    // Mid-bit point of a data bit
    assign sampleNow = (state == dataSt) && tick && (tickCnt == lastTick);

    // -------------------------------------------------------------------------
    // Frame FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            state    <= idleSt;
            tickCnt  <= '0;
            bitCnt   <= '0;
            rxValid  <= 1'b0;
            frameErr <= 1'b0;
        end
        else
        begin
            rxValid  <= 1'b0;                       // Strobes
            frameErr <= 1'b0;
            case (state)
                idleSt:
                    if (rxPrev && !rxSync)          // Falling start edge
                    begin
                        state   <= startSt;
                        tickCnt <= '0;
                    end
                startSt:
                    if (tick)
                    begin
                        if (tickCnt == halfBit)
                        begin
                            tickCnt <= '0;
                            bitCnt  <= '0;
                            state   <= rxSync ? idleSt : dataSt;  // Glitch back to idle
                        end
                        else
                            tickCnt <= tickCnt + 1'b1;
                    end
                dataSt:
                    if (tick)
                    begin
                        tickCnt <= tickCnt + 1'b1;  // Wraps at 16
                        if (sampleNow)
                        begin
                            bitCnt <= bitCnt + 1'b1;
                            if (bitCnt == lastBit)
                                state <= stopSt;
                        end
                    end
                default:                            // Stop bit
                    if (tick)
                    begin
                        tickCnt <= tickCnt + 1'b1;
                        if (tickCnt == lastTick)
                        begin
                            state    <= idleSt;
                            rxValid  <= rxSync;
                            frameErr <= !rxSync;
                        end
                    end
            endcase
        end
    end

    // Data shift, LSB arrives first
    always_ff @(posedge clk)
    begin
        if (sampleNow)
            shiftReg <= {rxSync, shiftReg[uartPkg::byteWidth-1:1]};
    end

    assign rxByte = shiftReg;

    // Frame end strobes are one cycle wide, one push per frame
    assert property (@(posedge clk) disable iff (!RSTn)
        (rxValid || frameErr) |=> !(rxValid || frameErr));

endmodule

`default_nettype wire

//--- hw/uartRxFifo.sv
// Show-ahead receive FIFO between the serial receiver and the bus registers, with overrun flag
`timescale 1ns/1ps
`default_nettype none

module uartRxFifo #(
    parameter int depthLog2 = 2
) (
    input  logic                           clk,
    input  logic                           RSTn,
    input  logic                           push,
    input  logic [uartPkg::byteWidth-1:0]  pushData,
    input  logic                           pop,
    input  logic                           clearOverrun,
    output logic [uartPkg::byteWidth-1:0]  head,       // Oldest byte, always shown
    output logic                           notEmpty,
    output logic                           overrun     // Sticky
);

    localparam int depth = 1 << depthLog2;

    logic [uartPkg::byteWidth-1:0] mem [depth];
    logic [depthLog2-1:0]          wrPtr;
    logic [depthLog2-1:0]          rdPtr;
    logic [depthLog2:0]            count;      // One bit wider than pointers
    logic                          full;
    logic                          doPush;
    logic                          doPop;

    assign full     = (count == (depthLog2 + 1)'(depth));
    assign notEmpty = (count != '0);
    assign doPush   = push && !full;           // Full drops the byte
    assign doPop    = pop && notEmpty;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;          // Natural wrap
            if (doPop)
                rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
            if (push && full)
                overrun <= 1'b1;                // Set wins over clear
            else if (clearOverrun)
                overrun <= 1'b0;
        end
    end

    // Storage
    always_ff @(posedge clk)
    begin
        if (doPush)
            mem[wrPtr] <= pushData;
    end

    assign head = mem[rdPtr];

    // Register block only pops what it has seen
    assert property (@(posedge clk) disable iff (!RSTn) pop |-> notEmpty);
    assert property (@(posedge clk) disable iff (!RSTn) count <= (depthLog2 + 1)'(depth));

endmodule

`default_nettype wire

//--- hw/uartTransmitter.sv
// 8N1 serial transmitter, sends one frame per start strobe and reports busy until the stop bit ends
`timescale 1ns/1ps
`default_nettype none

module uartTransmitter (
    input  logic                           clk,
    input  logic                           RSTn,
    input  logic                           tick,
    input  logic                           txStart,
    input  logic [uartPkg::byteWidth-1:0]  txByte,
    output logic                           TXD,
    output logic                           busy
);

    localparam int frameBits = uartPkg::byteWidth + 2;   // Start, data, stop
    localparam int cntWidth  = $clog2(uartPkg::overSample);
    localparam int bitWidth  = $clog2(frameBits);

    localparam logic [cntWidth-1:0] lastTick = cntWidth'(uartPkg::overSample - 1);
    localparam logic [bitWidth-1:0] lastBit  = bitWidth'(frameBits - 1);

    logic [frameBits-1:0] frame;       // Bit 0 is on the line
    logic [cntWidth-1:0]  tickCnt;
    logic [bitWidth-1:0]  bitCnt;

    // -------------------------------------------------------------------------
    // Load and shift
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            frame   <= '1;                 // Line idles high
            tickCnt <= '0;
            bitCnt  <= '0;
            busy    <= 1'b0;
        end
        else if (txStart && !busy)
        begin
            frame   <= {1'b1, txByte, 1'b0};
            tickCnt <= '0;
            bitCnt  <= '0;
            busy    <= 1'b1;
        end
        else if (busy && tick)
        begin
            tickCnt <= tickCnt + 1'b1;
            if (tickCnt == lastTick)       // 16 ticks per bit
            begin
                frame  <= {1'b1, frame[frameBits-1:1]};   // Back-fill with idle level
                bitCnt <= bitCnt + 1'b1;
                if (bitCnt == lastBit)
                    busy <= 1'b0;          // Stop bit done
            end
        end
    end

    assign TXD = frame[0];

    // Register block holds writes off while a frame is out
    assert property (@(posedge clk) disable iff (!RSTn) txStart |-> !busy);

endmodule

`default_nettype wire

//--- hw/ahbUartRegs.sv
// AHB-Lite slave register block of the UART: data, status and control words, zero wait states
`timescale 1ns/1ps
`default_nettype none

module ahbUartRegs (
    input  logic                           clk,
    input  logic                           RSTn,
    input  logic                           HSEL,
    input  logic [uartPkg::busWidth-1:0]   HADDR,
    input  logic [1:0]                     HTRANS,
    input  logic                           HWRITE,
    input  logic [uartPkg::busWidth-1:0]   HWDATA,
    input  logic                           HREADY,
    output logic [uartPkg::busWidth-1:0]   HRDATA,
    input  logic [uartPkg::byteWidth-1:0]  head,
    input  logic                           notEmpty,
    input  logic                           overrun,
    input  logic                           frameErr,
    input  logic                           busy,
    output logic                           pop,
    output logic                           clearOverrun,
    output logic                           txStart,
    output logic [uartPkg::byteWidth-1:0]  txByte,
    output logic [uartPkg::divWidth-1:0]   divisor,
    output logic                           irq
);

    logic                           accept;
    logic                           wrEn;        // Data phase of a write
    logic                           rdEn;        // Data phase of a read
    logic [1:0]                     addrReg;
    logic                           rxIrqEn;
    logic                           frameFlag;   // Sticky frame error
    uartPkg::regWord                wrWord;
    uartPkg::regWord                ctrlWord;
    logic [uartPkg::busWidth-1:0]   rdWord;

    // -------------------------------------------------------------------------
    // Address phase
    // -------------------------------------------------------------------------
    assign accept = HSEL && HTRANS[1] && HREADY;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            wrEn    <= 1'b0;
            rdEn    <= 1'b0;
            addrReg <= '0;
        end
        else
        begin
            wrEn    <= accept && HWRITE;
            rdEn    <= accept && !HWRITE;
            addrReg <= HADDR[3:2];                  // Word select
        end
    end

    // -------------------------------------------------------------------------
    // Data phase strobes
    // -------------------------------------------------------------------------
    assign wrWord       = HWDATA;
    assign txByte       = wrWord.txView.txData;
    assign txStart      = wrEn && (addrReg == uartPkg::dataOffset) && !busy;  // Busy drops it
    assign pop          = rdEn && (addrReg == uartPkg::dataOffset) && notEmpty;
    assign clearOverrun = rdEn && (addrReg == uartPkg::statusOffset);

    // Control, flag and interrupt state
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            divisor   <= uartPkg::divWidth'(uartPkg::resetDivisor);
            rxIrqEn   <= 1'b0;
            frameFlag <= 1'b0;
            irq       <= 1'b0;
        end
        else
        begin
            if (wrEn && (addrReg == uartPkg::ctrlOffset))
            begin
                divisor <= wrWord.ctrlView.divisor;
                rxIrqEn <= wrWord.ctrlView.rxIrqEn;
            end
            if (frameErr)
                frameFlag <= 1'b1;                  // New error beats the clear
            else if (clearOverrun)
                frameFlag <= 1'b0;
            irq <= rxIrqEn && notEmpty;
        end
    end

    // -------------------------------------------------------------------------
    // Read mux
    // -------------------------------------------------------------------------
    always_comb
    begin
        ctrlWord                  = '0;
        ctrlWord.ctrlView.rxIrqEn = rxIrqEn;
        ctrlWord.ctrlView.divisor = divisor;
        rdWord                    = '0;
        case (addrReg)
            uartPkg::dataOffset:
            begin
                rdWord[uartPkg::byteWidth-1:0] = head;
                rdWord[uartPkg::dataValidBit]  = notEmpty;
            end
            uartPkg::statusOffset:
            begin
                rdWord[uartPkg::statRxReady]  = notEmpty;
                rdWord[uartPkg::statTxBusy]   = busy;
                rdWord[uartPkg::statOverrun]  = overrun;
                rdWord[uartPkg::statFrameErr] = frameFlag;
            end
            uartPkg::ctrlOffset:
                rdWord = ctrlWord;
            default:
                rdWord = '0;                        // Unmapped word
        endcase
    end

    assign HRDATA = rdEn ? rdWord : '0;

endmodule

`default_nettype wire

//--- hw/ahbUart.sv
// UART peripheral top level, an AHB-Lite slave joining baud tick, receiver, FIFO and transmitter
`timescale 1ns/1ps
`default_nettype none

module ahbUart #(
    parameter int depthLog2 = 2                     // Receive FIFO of 4
) (
    input  logic                          clk,
    input  logic                          RSTn,
    input  logic                          HSEL,
    input  logic [uartPkg::busWidth-1:0]  HADDR,
    input  logic [1:0]                    HTRANS,
    input  logic                          HWRITE,
    input  logic [uartPkg::busWidth-1:0]  HWDATA,
    input  logic                          HREADY,
    output logic [uartPkg::busWidth-1:0]  HRDATA,
    input  logic                          RXD,
    output logic                          TXD,
    output logic                          irq
);

    logic [uartPkg::divWidth-1:0]  divisor;
    logic                          tick;
    logic [uartPkg::byteWidth-1:0] rxByte;
    logic                          rxValid;
    logic                          frameErr;
    logic [uartPkg::byteWidth-1:0] head;
    logic                          notEmpty;
    logic                          overrun;
    logic                          pop;
    logic                          clearOverrun;
    logic                          txStart;
    logic [uartPkg::byteWidth-1:0] txByte;
    logic                          busy;

    // -------------------------------------------------------------------------
    // Shared bit-rate source
    // -------------------------------------------------------------------------
    uartBaudTick baudTick_i (
        .clk     (clk),
        .RSTn    (RSTn),
        .divisor (divisor),
        .tick    (tick)
    );

    // Receive path, receiver into FIFO
    uartReceiver receiver_i (
        .clk      (clk),
        .RSTn     (RSTn),
        .tick     (tick),
        .RXD      (RXD),
        .rxByte   (rxByte),
        .rxValid  (rxValid),
        .frameErr (frameErr)
    );

    uartRxFifo #(
        .depthLog2 (depthLog2)
    ) rxFifo_i (
        .clk          (clk),
        .RSTn         (RSTn),
        .push         (rxValid),
        .pushData     (rxByte),
        .pop          (pop),
        .clearOverrun (clearOverrun),
        .head         (head),
        .notEmpty     (notEmpty),
        .overrun      (overrun)
    );

    // Transmit path
    uartTransmitter transmitter_i (
        .clk     (clk),
        .RSTn    (RSTn),
        .tick    (tick),
        .txStart (txStart),
        .txByte  (txByte),
        .TXD     (TXD),
        .busy    (busy)
    );

    // -------------------------------------------------------------------------
    // Bus side
    // -------------------------------------------------------------------------
    ahbUartRegs regs_i (
        .clk          (clk),
        .RSTn         (RSTn),
        .HSEL         (HSEL),
        .HADDR        (HADDR),
        .HTRANS       (HTRANS),
        .HWRITE       (HWRITE),
        .HWDATA       (HWDATA),
        .HREADY       (HREADY),
        .HRDATA       (HRDATA),
        .head         (head),
        .notEmpty     (notEmpty),
        .overrun      (overrun),
        .frameErr     (frameErr),
        .busy         (busy),
        .pop          (pop),
        .clearOverrun (clearOverrun),
        .txStart      (txStart),
        .txByte       (txByte),
        .divisor      (divisor),
        .irq          (irq)
    );

endmodule

`default_nettype wire

//--- sim/ahbUartTb.sv
// Testbench for the AHB UART, runs a table of bus and serial transactions against the top level
`timescale 1ns/1ps
`default_nettype none

module ahbUartTb;

    localparam int depthLog2 = 2;
    localparam int fifoDepth = 1 << depthLog2;
    localparam int ticksPerBit = 16;
    localparam int maxDivisor = 3;                   // Largest divisor in the table
    localparam logic [31:0] addrData   = 32'h0;
    localparam logic [31:0] addrStatus = 32'h4;
    localparam logic [31:0] addrCtrl   = 32'h8;

    // Entry kinds
    localparam int kRx = 0;
    localparam int kTx = 1;
    localparam int kCtrl = 2;
    localparam int kBadStop = 3;

    // -------------------------------------------------------------------------
    // Stimulus table: kind, byte or control word, expected read word
    // -------------------------------------------------------------------------
    localparam int numEntries = 7;
    localparam int kindTab [numEntries] = '{kCtrl, kRx, kRx, kRx, kBadStop, kTx, kTx};
    localparam logic [31:0] dataTab [numEntries] = '{32'h0001_0003, 32'hA5, 32'h3C, 32'h81,
                                                     32'h5A, 32'h96, 32'h4B};
    localparam logic [31:0] expTab [numEntries] = '{32'h0001_0003, 32'h1A5, 32'h13C, 32'h181,
                                                    32'h8, 32'h2, 32'h2};   // Status for tx
    localparam int cycleLimit = (numEntries + fifoDepth + 1) * 12 * (maxDivisor + 1)
                                * ticksPerBit + 2000;

    logic        clk;
    logic        RSTn;
    logic        HSEL;
    logic [31:0] HADDR;
    logic [1:0]  HTRANS;
    logic        HWRITE;
    logic [31:0] HWDATA;
    logic        HREADY;
    logic [31:0] HRDATA;
    logic        RXD;
    logic        TXD;
    logic        irq;

    int          errors = 0;
    int          cycleCount = 0;
    int          bitClocks = ticksPerBit * 2;        // Reset divisor of 1
    logic [31:0] expQ [$];                           // Bytes waiting in the FIFO

    ahbUart #(.depthLog2(depthLog2)) dut_i (
        .clk(clk), .RSTn(RSTn), .HSEL(HSEL), .HADDR(HADDR), .HTRANS(HTRANS),
        .HWRITE(HWRITE), .HWDATA(HWDATA), .HREADY(HREADY), .HRDATA(HRDATA),
        .RXD(RXD), .TXD(TXD), .irq(irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timed out after %0d cycles", cycleCount);
            $display("Run ended with %0d errors", errors);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic compareWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Address phase, then idle bus in the data phase, sampled mid-cycle
    task automatic readReg(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        HSEL   <= 1'b1;
        HTRANS <= 2'b10;                             // NONSEQ
        HWRITE <= 1'b0;
        HADDR  <= addr;
        @(posedge clk);
        HSEL   <= 1'b0;
        HTRANS <= 2'b00;
        @(negedge clk);
        data = HRDATA;
    endtask

    task automatic writeReg(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        HSEL   <= 1'b1;
        HTRANS <= 2'b10;
        HWRITE <= 1'b1;
        HADDR  <= addr;
        @(posedge clk);
        HSEL   <= 1'b0;
        HTRANS <= 2'b00;
        HWDATA <= data;                              // Data phase
        @(posedge clk);
    endtask

    // One 8N1 frame on RXD plus one idle bit time
    task automatic driveFrame(input logic [7:0] value, input logic stopBit);
        logic [9:0] bits;
        int i;
        bits = {stopBit, value, 1'b0};
        for (i = 0; i < 10; i++)
        begin
            @(posedge clk);
            RXD <= bits[i];
            repeat (bitClocks - 1) @(posedge clk);
        end
        @(posedge clk);
        RXD <= 1'b1;
        repeat (bitClocks - 1) @(posedge clk);
    endtask

    // Find the start bit on TXD, then sample each bit at its middle
    task automatic decodeFrame(output logic [7:0] value);
        int waitCycles;
        int i;
        waitCycles = 0;
        value = '0;
        @(negedge clk);
        while (TXD !== 1'b0 && waitCycles < 4 * bitClocks)
        begin
            @(negedge clk);
            waitCycles++;
        end
        if (TXD !== 1'b0)
        begin
            errors++;
            $display("No start bit appeared on TXD by %0t", $time);
        end
        else
        begin
            repeat (bitClocks / 2) @(negedge clk);
            compareWord("TXD start bit", 32'(TXD), 32'h0);
            for (i = 0; i < 8; i++)
            begin
                repeat (bitClocks) @(negedge clk);
                value[i] = TXD;                      // LSB first
            end
            repeat (bitClocks) @(negedge clk);
            compareWord("TXD stop bit", 32'(TXD), 32'h1);
        end
    endtask

    // Pop every queued byte, then expect irq low and an empty read
    task automatic drainFifo();
        logic [31:0] word;
        while (expQ.size() > 0)
        begin
            readReg(addrData, word);
            compareWord("DATA", word, expQ.pop_front());
        end
        repeat (2) @(negedge clk);                   // Registered irq
        compareWord("irq", 32'(irq), 32'h0);
        readReg(addrData, word);
        compareWord("DATA valid bit", word & 32'h100, 32'h0);
    endtask

    // Frame out, busy seen mid-frame, a second write dropped
    task automatic checkTransmit(input logic [7:0] value, input logic [31:0] expStatus);
        logic [31:0] word;
        logic [7:0]  got;
        int tries;
        int quiet;
        writeReg(addrData, {24'h0, value});
        fork
            decodeFrame(got);
            begin
                readReg(addrStatus, word);
                compareWord("STATUS", word, expStatus);
                writeReg(addrData, {24'h0, ~value});  // Must be ignored
            end
        join
        compareWord("TXD byte", {24'h0, got}, {24'h0, value});
        tries = 0;
        word = 32'h2;
        while (word[1] && tries < 100)
        begin
            readReg(addrStatus, word);
            tries++;
        end
        if (word[1])
        begin
            errors++;
            $display("Transmitter stayed busy after the frame at %0t", $time);
        end
        quiet = 1;
        repeat (2 * bitClocks)
        begin
            @(negedge clk);
            if (TXD !== 1'b1)
                quiet = 0;
        end
        if (quiet == 0)
        begin
            errors++;
            $display("A second frame appeared on TXD at %0t", $time);
        end
    endtask

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial
    begin
        int n;
        int seedVal;
        logic [31:0] word;
        logic [7:0]  filler;
        seedVal = $urandom(60);
        RSTn   = 1'b0;
        HSEL   = 1'b0;
        HADDR  = '0;
        HTRANS = 2'b00;
        HWRITE = 1'b0;
        HWDATA = '0;
        HREADY = 1'b1;                               // No other slave stalls
        RXD    = 1'b1;                               // Idle line
        repeat (5) @(posedge clk);
        RSTn <= 1'b1;
        @(negedge clk);
        compareWord("TXD", 32'(TXD), 32'h1);
        compareWord("irq", 32'(irq), 32'h0);
        readReg(addrStatus, word);
        compareWord("STATUS", word, 32'h0);
        readReg(addrCtrl, word);
        compareWord("CTRL", word, 32'h0000_0001);    // Divisor 1, rxIrqEn clear

        for (n = 0; n < numEntries; n++)
        begin
            if (kindTab[n] != kRx && expQ.size() > 0)
                drainFifo();
            case (kindTab[n])
                kCtrl:
                begin
                    writeReg(addrCtrl, dataTab[n]);
                    bitClocks = ticksPerBit * (int'(dataTab[n][15:0]) + 1);
                    readReg(addrCtrl, word);
                    compareWord("CTRL", word, expTab[n]);
                end
                kRx:
                begin
                    driveFrame(dataTab[n][7:0], 1'b1);
                    expQ.push_back(expTab[n]);
                    @(negedge clk);
                    compareWord("irq", 32'(irq), 32'h1);   // Byte waiting
                end
                kBadStop:
                begin
                    driveFrame(dataTab[n][7:0], 1'b0);
                    readReg(addrStatus, word);
                    compareWord("STATUS", word, expTab[n]);
                    readReg(addrStatus, word);
                    compareWord("STATUS", word, 32'h0);     // Cleared by the read
                    readReg(addrData, word);
                    compareWord("DATA valid bit", word & 32'h100, 32'h0);
                end
                default:
                    checkTransmit(dataTab[n][7:0], expTab[n]);
            endcase
        end
        if (expQ.size() > 0)
            drainFifo();

        // Overrun, one byte more than the FIFO holds
        for (n = 0; n <= fifoDepth; n++)
        begin
            filler = 8'($urandom);
            driveFrame(filler, 1'b1);
            if (n < fifoDepth)
                expQ.push_back({23'h0, 1'b1, filler});
        end
        readReg(addrStatus, word);
        compareWord("STATUS", word, 32'h5);          // rxReady and overrun
        readReg(addrStatus, word);
        compareWord("STATUS", word, 32'h1);
        drainFifo();

        $display("Run ended with %0d errors", errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/uartPkg.sv
hw/uartBaudTick.sv
hw/uartReceiver.sv
hw/uartRxFifo.sv
hw/uartTransmitter.sv
hw/ahbUartRegs.sv
hw/ahbUart.sv
sim/ahbUartTb.sv

//--- run.sh
#!/bin/sh
# Build the AHB UART testbench with Verilator, run it and scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module ahbUartTb -o ahbUartSim > build.log 2>&1 \
    && ./obj_dir/ahbUartSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -qF "** FAIL **" sim.log && { echo "Simulation reported failure"; exit 1; }
exit 0
